// File: beat_timer.sv
// Response timeout counter for the beat on the bus
`timescale 1ns/1ps
`default_nettype none

module beat_timer #(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  wire  clk_i,
	input  wire  rst_i,
	input  wire  issue_i,
	input  wire  beat_end_i,
	output logic expired_o
);
	localparam int CNT_W = $clog2(TIMEOUT_CYCLES);

	logic [CNT_W-1:0] cnt_q;
	logic             open_q;

	// Fires in the last allowed cycle of the open beat
	assign expired_o = open_q && (cnt_q == CNT_W'(TIMEOUT_CYCLES - 1));

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			cnt_q  <= '0;
			open_q <= 1'b0;
		end else if (issue_i) begin
			cnt_q  <= '0;
			open_q <= 1'b1;
		end else if (beat_end_i || expired_o) begin
			open_q <= 1'b0;
		end else if (open_q) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	a_expire_single: assert property (@(posedge clk_i) disable iff (rst_i)
		expired_o |=> !expired_o)
		else $error("beat_timer: expiry held for two cycles");

endmodule

`default_nettype wire

// File: bus_master.sv
// Registered memory bus request fields for the beat being issued
`timescale 1ns/1ps
`default_nettype none

module bus_master (
	input  wire                      clk_i,
	input  wire                      rst_i,
	input  wire                      capture_i,
	input  wire                      issue_i,
	input  wire                      beat_end_i,
	input  wire                      we_i,
	input  wire                      load_mode_i,
	input  wire cache_pkg::line_adr_t adr_i,
	input  wire cache_pkg::beat_idx_t beat_idx_i,
	input  wire bus_pkg::beat_sel_t  sel_i,
	input  wire bus_pkg::beat_dat_t  dat_i,
	output logic                     bus_cyc_o,
	output logic                     bus_we_o,
	output bus_pkg::bus_adr_t        bus_adr_o,
	output bus_pkg::beat_sel_t       bus_sel_o,
	output bus_pkg::beat_dat_t       bus_dat_o
);
	import bus_pkg::*;
	import cache_pkg::*;

	line_adr_t adr_q;
	logic      we_q;

	// Request address and direction, held for the whole request
	always_ff @(posedge clk_i) begin
		if (capture_i) begin
			adr_q <= adr_i;
			we_q  <= we_i;
		end
	end

	// Load beats of an allocating write still read from memory
	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			bus_cyc_o <= 1'b0;
			bus_we_o  <= 1'b0;
			bus_sel_o <= '0;
		end else if (issue_i) begin
			bus_cyc_o <= 1'b1;
			bus_we_o  <= we_q && !load_mode_i;
			bus_sel_o <= sel_i;
		end else if (beat_end_i) begin
			bus_cyc_o <= 1'b0;
			bus_we_o  <= 1'b0;
			bus_sel_o <= '0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (issue_i) begin
			bus_adr_o <= {adr_q, beat_idx_i, {BEAT_ADR_LSB{1'b0}}};
			bus_dat_o <= dat_i;
		end
	end

	a_adr_steady: assert property (@(posedge clk_i) disable iff (rst_i)
		bus_cyc_o ##1 bus_cyc_o |-> $stable(bus_adr_o))
		else $error("bus_master: address changed during an open beat");

endmodule

`default_nettype wire

// File: bus_pkg.sv
// Memory bus types: address, data beat and byte enable widths
`default_nettype none

package bus_pkg;

	// ==================================================
	// Memory bus fields
	// ==================================================

	// Byte address on the memory bus
	typedef logic [31:0] bus_adr_t;

	// One data beat of the 128-bit bus
	typedef logic [127:0] beat_dat_t;

	// Byte enables for one beat, one bit per byte
	typedef logic [15:0] beat_sel_t;

	// Address bits that select a byte inside a beat
	localparam int BEAT_ADR_LSB = 4;

endpackage

`default_nettype wire

// File: cache_pkg.sv
// Cache line types: line data, line select, line address, beat index, cache class
`default_nettype none

package cache_pkg;

	// ==================================================
	// Cache line layout
	// ==================================================

	// A full 512-bit cache line
	typedef logic [511:0] line_t;

	// Byte select across a whole line
	typedef logic [63:0] line_sel_t;

	// Line address with the 6 offset bits removed
	typedef logic [25:0] line_adr_t;

	// Beat number inside a line
	typedef logic [1:0] beat_idx_t;

	localparam int BEATS_PER_LINE = 4;

	// Cache class of a request, decides between line load and strip access
	typedef enum logic {
		NON_CACHEABLE = 1'b0,
		CACHEABLE     = 1'b1
	} cache_class_t;

endpackage

`default_nettype wire

// File: dcache_fsm.sv
// Request FSM: sequences beats for line loads, strip accesses and the write merge
`timescale 1ns/1ps
`default_nettype none

module dcache_fsm (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire                     req_i,
	input  wire                     req_we_i,
	input  wire cache_pkg::cache_class_t req_class_i,
	input  wire                     bus_ack_i,
	input  wire                     bus_rty_i,
	input  wire                     expired_i,
	input  wire bus_pkg::beat_sel_t beat_sel_i,
	output logic                    busy_o,
	output logic                    done_o,
	output logic                    err_o,
	output logic                    load_o,
	output logic                    issue_o,
	output logic                    beat_end_o,
	output cache_pkg::beat_idx_t    beat_idx_o,
	output logic                    load_mode_o,
	output logic                    merge_o,
	output logic                    capture_o
);
	import cache_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		LOAD_ISSUE,
		LOAD_WAIT,
		MERGE,
		STRIP_ISSUE,
		STRIP_WAIT,
		FINISH
	} state_t;

	state_t       state_q;
	beat_idx_t    idx_q;
	logic         we_q;
	cache_class_t class_q;
	logic         err_q;
	logic         beat_open;
	logic         last_beat;

	// A beat is open while its request sits on the bus
	assign beat_open = (state_q == LOAD_WAIT) || (state_q == STRIP_WAIT);
	assign last_beat = (idx_q == beat_idx_t'(BEATS_PER_LINE - 1));

	assign capture_o   = (state_q == IDLE) && req_i;
	// Strip beats with an empty select group never reach the bus
	assign issue_o     = (state_q == LOAD_ISSUE) || ((state_q == STRIP_ISSUE) && (|beat_sel_i));
	assign beat_end_o  = beat_open && (bus_ack_i || bus_rty_i || expired_i);
	assign load_mode_o = (state_q == LOAD_ISSUE) || (state_q == LOAD_WAIT);
	assign merge_o     = (state_q == MERGE);
	assign beat_idx_o  = idx_q;
	assign busy_o      = (state_q != IDLE);
	assign done_o      = (state_q == FINISH);
	assign err_o       = done_o && err_q;
	assign load_o      = done_o && (class_q == CACHEABLE) && !err_q;

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			state_q <= IDLE;
			idx_q   <= '0;
			we_q    <= 1'b0;
			class_q <= NON_CACHEABLE;
			err_q   <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (req_i) begin
						we_q    <= req_we_i;
						class_q <= req_class_i;
						err_q   <= 1'b0;
						idx_q   <= '0;
						state_q <= (req_class_i == CACHEABLE) ? LOAD_ISSUE : STRIP_ISSUE;
					end
				end
				LOAD_ISSUE: state_q <= LOAD_WAIT;
				LOAD_WAIT: begin
					// The index wraps to zero after the fourth beat, ready for the write-through
					if (bus_ack_i) begin
						idx_q <= idx_q + 1'b1;
						if (last_beat)
							state_q <= we_q ? MERGE : FINISH;
						else
							state_q <= LOAD_ISSUE;
					end else if (bus_rty_i) begin
						state_q <= LOAD_ISSUE;
					end else if (expired_i) begin
						err_q   <= 1'b1;
						state_q <= FINISH;
					end
				end
				MERGE: state_q <= STRIP_ISSUE;
				STRIP_ISSUE: begin
					if (|beat_sel_i)
						state_q <= STRIP_WAIT;
					else if (last_beat)
						state_q <= FINISH;
					else
						idx_q <= idx_q + 1'b1;
				end
				STRIP_WAIT: begin
					if (bus_ack_i) begin
						idx_q   <= idx_q + 1'b1;
						state_q <= last_beat ? FINISH : STRIP_ISSUE;
					end else if (bus_rty_i) begin
						state_q <= STRIP_ISSUE;
					end else if (expired_i) begin
						err_q   <= 1'b1;
						state_q <= FINISH;
					end
				end
				FINISH: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// ==================================================
	// Beat protocol checks
	// ==================================================

	// An issue never follows a cycle in which a beat stayed open
	a_issue_when_closed: assert property (@(posedge clk_i) disable iff (rst_i)
		issue_o |-> !$past(beat_open) || $past(beat_end_o))
		else $error("dcache_fsm: issue while a beat is open");

	// A beat can only end after an issue opened it
	a_end_in_open_beat: assert property (@(posedge clk_i) disable iff (rst_i)
		beat_end_o |-> $past(issue_o) || ($past(beat_open) && !$past(beat_end_o)))
		else $error("dcache_fsm: beat end without an open beat");

endmodule

`default_nettype wire

// File: dcache_miss_ctrl.sv
// Data cache miss and uncached access controller, top level
`timescale 1ns/1ps
`default_nettype none

module dcache_miss_ctrl #(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire                          req_i,
	input  wire                          req_we_i,
	input  wire cache_pkg::cache_class_t req_class_i,
	input  wire cache_pkg::line_adr_t    req_adr_i,
	input  wire cache_pkg::line_sel_t    req_sel_i,
	input  wire cache_pkg::line_t        req_dat_i,
	output wire                          busy_o,
	output wire                          done_o,
	output wire                          err_o,
	output wire                          load_o,
	output wire cache_pkg::line_t        line_o,
	output wire                          bus_cyc_o,
	output wire                          bus_we_o,
	output wire bus_pkg::bus_adr_t       bus_adr_o,
	output wire bus_pkg::beat_sel_t      bus_sel_o,
	output wire bus_pkg::beat_dat_t      bus_dat_o,
	input  wire                          bus_ack_i,
	input  wire                          bus_rty_i,
	input  wire bus_pkg::beat_dat_t      bus_dat_i
);
	import bus_pkg::*;
	import cache_pkg::*;

	logic      issue;
	logic      beat_end;
	logic      expired;
	logic      capture;
	logic      load_mode;
	logic      merge;
	beat_idx_t beat_idx;
	beat_sel_t beat_sel;
	beat_dat_t beat_dat;

	dcache_fsm u_fsm (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req_i       (req_i),
		.req_we_i    (req_we_i),
		.req_class_i (req_class_i),
		.bus_ack_i   (bus_ack_i),
		.bus_rty_i   (bus_rty_i),
		.expired_i   (expired),
		.beat_sel_i  (beat_sel),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.err_o       (err_o),
		.load_o      (load_o),
		.issue_o     (issue),
		.beat_end_o  (beat_end),
		.beat_idx_o  (beat_idx),
		.load_mode_o (load_mode),
		.merge_o     (merge),
		.capture_o   (capture)
	);

	beat_timer #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) u_timer (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.issue_i    (issue),
		.beat_end_i (beat_end),
		.expired_o  (expired)
	);

	bus_master u_bus (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.capture_i   (capture),
		.issue_i     (issue),
		.beat_end_i  (beat_end),
		.we_i        (req_we_i),
		.load_mode_i (load_mode),
		.adr_i       (req_adr_i),
		.beat_idx_i  (beat_idx),
		.sel_i       (beat_sel),
		.dat_i       (beat_dat),
		.bus_cyc_o   (bus_cyc_o),
		.bus_we_o    (bus_we_o),
		.bus_adr_o   (bus_adr_o),
		.bus_sel_o   (bus_sel_o),
		.bus_dat_o   (bus_dat_o)
	);

	line_assembler u_line (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.capture_i   (capture),
		.req_sel_i   (req_sel_i),
		.req_dat_i   (req_dat_i),
		.beat_idx_i  (beat_idx),
		.load_mode_i (load_mode),
		.merge_i     (merge),
		.bus_ack_i   (bus_ack_i),
		.bus_we_i    (bus_we_o),
		.bus_dat_i   (bus_dat_i),
		.beat_sel_o  (beat_sel),
		.beat_dat_o  (beat_dat),
		.line_o      (line_o)
	);

endmodule

`default_nettype wire

// File: flist.f
bus_pkg.sv
cache_pkg.sv
dcache_fsm.sv
beat_timer.sv
bus_master.sv
line_assembler.sv
dcache_miss_ctrl.sv
tb_dcache_miss_ctrl.sv

// File: line_assembler.sv
// Line buffer: holds CPU data, collects read beats and merges write bytes
`timescale 1ns/1ps
`default_nettype none

module line_assembler (
	input  wire                       clk_i,
	input  wire                       rst_i,
	input  wire                       capture_i,
	input  wire cache_pkg::line_sel_t req_sel_i,
	input  wire cache_pkg::line_t     req_dat_i,
	input  wire cache_pkg::beat_idx_t beat_idx_i,
	input  wire                       load_mode_i,
	input  wire                       merge_i,
	input  wire                       bus_ack_i,
	input  wire                       bus_we_i,
	input  wire bus_pkg::beat_dat_t   bus_dat_i,
	output bus_pkg::beat_sel_t        beat_sel_o,
	output bus_pkg::beat_dat_t        beat_dat_o,
	output cache_pkg::line_t          line_o
);
	import bus_pkg::*;
	import cache_pkg::*;

	localparam int BEAT_W = $bits(beat_dat_t);
	localparam int SEL_W  = $bits(beat_sel_t);
	localparam int NBYTES = $bits(line_sel_t);

	line_sel_t sel_q;
	line_t     dat_q;
	line_t     line_q;

	always_ff @(posedge clk_i) begin
		if (capture_i) begin
			sel_q <= req_sel_i;
			dat_q <= req_dat_i;
		end
	end

	// ==================================================
	// Result line
	// ==================================================

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			line_q <= '0;
		end else if (capture_i) begin
			line_q <= '0;
		end else if (merge_i) begin
			for (int b = 0; b < NBYTES; b++) begin
				if (sel_q[b])
					line_q[b*8 +: 8] <= dat_q[b*8 +: 8];
			end
		end else if (bus_ack_i && !bus_we_i) begin
			// Read data lands in the slice of the beat that was acked
			line_q[beat_idx_i*BEAT_W +: BEAT_W] <= bus_dat_i;
		end
	end

	// Line loads always fetch whole beats
	assign beat_sel_o = load_mode_i ? {SEL_W{1'b1}} : sel_q[beat_idx_i*SEL_W +: SEL_W];
	assign beat_dat_o = dat_q[beat_idx_i*BEAT_W +: BEAT_W];
	assign line_o     = line_q;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_dcache_miss_ctrl \
	-f flist.f -o sim_tb; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
exit 0

// File: tb_dcache_miss_ctrl.sv
// Testbench for the data cache miss controller
// LFSR stimulus, memory bus responder, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_miss_ctrl;
	import bus_pkg::*;
	import cache_pkg::*;

	localparam int TIMEOUT_CYCLES = 16;
	localparam int NUM_REQS       = 60;
	localparam int WAIT_LIMIT     = 400;

	logic         clk_i;
	logic         rst_i;
	logic         req_i;
	logic         req_we_i;
	cache_class_t req_class_i;
	line_adr_t    req_adr_i;
	line_sel_t    req_sel_i;
	line_t        req_dat_i;
	logic         busy_o;
	logic         done_o;
	logic         err_o;
	logic         load_o;
	line_t        line_o;
	logic         bus_cyc_o;
	logic         bus_we_o;
	bus_adr_t     bus_adr_o;
	beat_sel_t    bus_sel_o;
	beat_dat_t    bus_dat_o;
	logic         bus_ack_i;
	logic         bus_rty_i;
	beat_dat_t    bus_dat_i;

	// Sparse memory, the expected beats of the running request and responder state
	line_t       mem [line_adr_t];
	logic [16:0] lfsr;
	bus_adr_t    exp_adr [$];
	logic        exp_we [$];
	beat_sel_t   exp_sel [$];
	beat_dat_t   exp_dat [$];
	logic        beat_seen;
	logic        beat_retry;
	logic        beat_hold;
	int          beat_delay;
	int          acked;
	int          hold_at;

	dcache_miss_ctrl #(
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) u_dut (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req_i       (req_i),
		.req_we_i    (req_we_i),
		.req_class_i (req_class_i),
		.req_adr_i   (req_adr_i),
		.req_sel_i   (req_sel_i),
		.req_dat_i   (req_dat_i),
		.busy_o      (busy_o),
		.done_o      (done_o),
		.err_o       (err_o),
		.load_o      (load_o),
		.line_o      (line_o),
		.bus_cyc_o   (bus_cyc_o),
		.bus_we_o    (bus_we_o),
		.bus_adr_o   (bus_adr_o),
		.bus_sel_o   (bus_sel_o),
		.bus_dat_o   (bus_dat_o),
		.bus_ack_i   (bus_ack_i),
		.bus_rty_i   (bus_rty_i),
		.bus_dat_i   (bus_dat_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// ==================================================
	// Helpers
	// ==================================================

	// 17-bit Fibonacci LFSR with taps 17 and 14, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[16] ^ lfsr[13];
			lfsr = {lfsr[15:0], fb};
			r    = {r[62:0], fb};
		end
		return r;
	endfunction

	task automatic abort(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopped at %0t ns", $time);
	endtask

	task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
		if (got !== exp)
			abort($sformatf("MISMATCH %s: got %0h expected %0h", name, got, exp));
	endtask

	// Lines never written hold a pattern made of the line address and word number
	function automatic line_t mem_line(input line_adr_t a);
		line_t l;
		if (mem.exists(a))
			return mem[a];
		for (int w = 0; w < 16; w++)
			l[w*32 +: 32] = {2'b10, a, 4'(w)};
		return l;
	endfunction

	function automatic line_t merge_bytes(input line_t old, input line_t dat, input line_sel_t sel);
		line_t l;
		l = old;
		for (int b = 0; b < 64; b++) begin
			if (sel[b])
				l[b*8 +: 8] = dat[b*8 +: 8];
		end
		return l;
	endfunction

	task automatic push_beat(input line_adr_t adr, input int k, input logic we,
			input beat_sel_t sel, input beat_dat_t dat);
		exp_adr.push_back({adr, 2'(k), 4'b0000});
		exp_we.push_back(we);
		exp_sel.push_back(sel);
		exp_dat.push_back(dat);
	endtask

	// ==================================================
	// Memory responder
	// ==================================================

	// Runs once per cycle, just after the inputs are driven
	task automatic respond();
		line_adr_t la;
		line_t     l;
		int        k;
		bus_ack_i = 1'b0;
		bus_rty_i = 1'b0;
		bus_dat_i = '0;
		if (!bus_cyc_o) begin
			beat_seen = 1'b0;
			return;
		end
		if (exp_adr.size() == 0)
			abort("A bus beat was issued when none was expected");
		// Fields must match the expected beat in every cycle that it stays open
		check("bus_adr_o", 512'(bus_adr_o), 512'(exp_adr[0]));
		check("bus_we_o", 512'(bus_we_o), 512'(exp_we[0]));
		check("bus_sel_o", 512'(bus_sel_o), 512'(exp_sel[0]));
		if (exp_we[0])
			check("bus_dat_o", 512'(bus_dat_o), 512'(exp_dat[0]));
		if (!beat_seen) begin
			beat_seen  = 1'b1;
			beat_hold  = (acked == hold_at);
			beat_retry = (rand_bits(3) == '0);
			beat_delay = int'(rand_bits(2));
		end
		if (beat_hold)
			return;
		if (beat_delay > 0) begin
			beat_delay--;
			return;
		end
		if (beat_retry) begin
			bus_rty_i = 1'b1;
			return;
		end
		la = bus_adr_o[31:6];
		k  = int'(bus_adr_o[5:4]);
		l  = mem_line(la);
		bus_ack_i = 1'b1;
		if (bus_we_o) begin
			for (int b = 0; b < 16; b++) begin
				if (bus_sel_o[b])
					l[k*128 + b*8 +: 8] = bus_dat_o[b*8 +: 8];
			end
			mem[la] = l;
		end else begin
			bus_dat_i = l[k*128 +: 128];
		end
		acked++;
		void'(exp_adr.pop_front());
		void'(exp_we.pop_front());
		void'(exp_sel.pop_front());
		void'(exp_dat.pop_front());
	endtask

	task automatic tick();
		@(posedge clk_i);
		#2;
		respond();
	endtask

	// ==================================================
	// Reference model and request sequence
	// ==================================================

	// A hold value of 0 to 3 withholds the response to that beat
	task automatic run_request(input logic we, input cache_class_t cls, input line_adr_t adr,
			input line_sel_t sel, input line_t dat, input int hold);
		line_t old_line;
		line_t exp_line;
		line_t exp_mem;
		logic  exp_err;
		logic  exp_load;
		int    n;
		old_line = mem_line(adr);
		exp_err  = (hold >= 0);
		exp_load = (cls == CACHEABLE) && !exp_err;
		if (cls == CACHEABLE) begin
			for (int k = 0; k < 4; k++)
				push_beat(adr, k, 1'b0, 16'hFFFF, '0);
		end
		if ((cls == NON_CACHEABLE) || we) begin
			for (int k = 0; k < 4; k++) begin
				if (sel[k*16 +: 16] != '0)
					push_beat(adr, k, we, sel[k*16 +: 16], dat[k*128 +: 128]);
			end
		end
		if (cls == CACHEABLE) begin
			exp_line = merge_bytes(old_line, dat, we ? sel : '0);
		end else begin
			// A strip read returns only the strips it touched
			exp_line = '0;
			for (int k = 0; k < 4; k++) begin
				if (!we && (sel[k*16 +: 16] != '0))
					exp_line[k*128 +: 128] = old_line[k*128 +: 128];
			end
		end
		exp_mem = (we && !exp_err) ? merge_bytes(old_line, dat, sel) : old_line;

		acked       = 0;
		hold_at     = hold;
		req_i       = 1'b1;
		req_we_i    = we;
		req_class_i = cls;
		req_adr_i   = adr;
		req_sel_i   = sel;
		req_dat_i   = dat;
		tick();
		req_i = 1'b0;
		n = 0;
		while (!done_o) begin
			if (n == WAIT_LIMIT)
				abort("Timed out waiting for done_o");
			// Busy holds and the result flags stay low until the request completes
			check("busy_o", 512'(busy_o), 512'(1));
			check("load_o", 512'(load_o), 512'(0));
			check("err_o", 512'(err_o), 512'(0));
			// A strobe with other fields while busy must be ignored
			req_i = (n == 2);
			if (req_i) begin
				req_adr_i = ~adr;
				req_dat_i = ~dat;
			end
			tick();
			n++;
		end
		req_i = 1'b0;

		check("busy_o", 512'(busy_o), 512'(1));
		check("err_o", 512'(err_o), 512'(exp_err));
		check("load_o", 512'(load_o), 512'(exp_load));
		if (!exp_err) begin
			check("line_o", line_o, exp_line);
			if (exp_adr.size() != 0)
				abort("The request ended before all expected bus beats were seen");
		end
		check("memory line", mem_line(adr), exp_mem);

		tick();
		check("done_o", 512'(done_o), 512'(0));
		check("busy_o", 512'(busy_o), 512'(0));
		check("bus_cyc_o", 512'(bus_cyc_o), 512'(0));
		tick();
		check("done_o", 512'(done_o), 512'(0));
		exp_adr.delete();
		exp_we.delete();
		exp_sel.delete();
		exp_dat.delete();
		hold_at = -1;
	endtask

	initial begin
		line_adr_t    adr;
		line_sel_t    sel;
		line_t        dat;
		logic [1:0]   kind;
		cache_class_t cls;
		int           hold;

		lfsr        = 17'd70461;
		rst_i       = 1'b1;
		req_i       = 1'b0;
		req_we_i    = 1'b0;
		req_class_i = NON_CACHEABLE;
		req_adr_i   = '0;
		req_sel_i   = '0;
		req_dat_i   = '0;
		bus_ack_i   = 1'b0;
		bus_rty_i   = 1'b0;
		bus_dat_i   = '0;
		beat_seen   = 1'b0;
		beat_retry  = 1'b0;
		beat_hold   = 1'b0;
		beat_delay  = 0;
		acked       = 0;
		hold_at     = -1;

		repeat (2) @(posedge clk_i);
		#2;
		rst_i = 1'b0;
		check("bus_cyc_o", 512'(bus_cyc_o), 512'(0));
		check("busy_o", 512'(busy_o), 512'(0));
		check("done_o", 512'(done_o), 512'(0));
		check("load_o", 512'(load_o), 512'(0));
		check("err_o", 512'(err_o), 512'(0));
		tick();

		// Directed cases first: full load, empty strip access, full merge, timeout
		dat = {16{32'h5A3C_96E1}};
		run_request(1'b0, CACHEABLE, {20'h35A1C, 6'd1}, '1, dat, -1);
		run_request(1'b0, NON_CACHEABLE, {20'h35A1C, 6'd2}, '0, dat, -1);
		run_request(1'b1, CACHEABLE, {20'h35A1C, 6'd3}, '1, dat, -1);
		run_request(1'b0, CACHEABLE, {20'h35A1C, 6'd4}, '1, dat, 1);

		for (int i = 0; i < NUM_REQS; i++) begin
			kind = 2'(rand_bits(2));
			adr  = {20'h35A1C, 6'(rand_bits(6))};
			for (int g = 0; g < 4; g++) begin
				sel[g*16 +: 16] = 16'(rand_bits(16));
				if (rand_bits(2) == '0)
					sel[g*16 +: 16] = '0;
			end
			for (int w = 0; w < 16; w++)
				dat[w*32 +: 32] = 32'(rand_bits(32));
			hold = ((i % 8) == 7) ? int'(rand_bits(2)) : -1;
			// Kinds 0 and 3 are cacheable, kinds 2 and 3 write
			cls = (kind[0] == kind[1]) ? CACHEABLE : NON_CACHEABLE;
			if (hold >= 0)
				cls = CACHEABLE;
			run_request(kind[1], cls, adr, sel, dat, hold);
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
